// ==== cps_video.f ====
+incdir+hw
hw/video_pkg.sv
hw/bus_pkg.sv
hw/video_timing.sv
hw/ppu_regs.sv
hw/pal_dma.sv
hw/pal_ram.sv
hw/cps_video.sv
bench/cps_video_assert.sv
bench/cps_video_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module cps_video_tb \
		-f cps_video.f --Mdir obj_dir -o cps_video_sim
	./obj_dir/cps_video_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/cps_video_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cps_video_settings.svh"

module cps_video_tb;

localparam int FRAME_CLKS = `CPS_H_TOTAL * `CPS_V_TOTAL;
localparam int PAL_USED   = `CPS_PAL_PAGES * `CPS_PAGE_SIZE;
localparam int VRAM_WORDS = 1 << $bits(bus_pkg::vram_addr_t);
localparam longint TIMEOUT_NS = 64'd8 * FRAME_CLKS * 8;
localparam bus_pkg::reg_addr_t ADDR_BASE  = bus_pkg::REG_PAL_BASE;
localparam bus_pkg::reg_addr_t ADDR_PAGES = bus_pkg::REG_PAL_PAGES;

logic                  clk;
logic                  rst;
logic                  reg_cs;
logic                  reg_we;
bus_pkg::reg_addr_t    reg_addr;
bus_pkg::word_t        cpu_dout;
bus_pkg::word_t        mmr_dout;
logic                  busreq;
logic                  busack;
bus_pkg::vram_addr_t   vram_addr;
bus_pkg::word_t        vram_data;
logic                  vram_ok;
logic                  vram_cs;
video_pkg::pal_idx_t   pxl_in;
video_pkg::hcount_t    hdump;
video_pkg::vcount_t    vdump;
logic                  hb;
logic                  vb;
logic                  hs;
logic                  vs;
video_pkg::chan_t      red;
video_pkg::chan_t      green;
video_pkg::chan_t      blue;
logic                  lhbl_dly;
logic                  lvbl_dly;

// Video RAM contents and the expected palette
bus_pkg::word_t        vmem [VRAM_WORDS];
video_pkg::pal_word_t  model_pal [PAL_USED];

// Register values as last committed, and those a running copy uses
bus_pkg::word_t        sh_base;
video_pkg::page_mask_t sh_mask;
bus_pkg::word_t        act_base;
video_pkg::page_mask_t act_mask;
int                    copies_started;
int                    copies_done;
int                    colour_checks;
bit                    pix_on;
bit                    passed;
bit                    fail_shown;

cps_video dut (
    .clk       ( clk       ),
    .rst       ( rst       ),
    .reg_cs    ( reg_cs    ),
    .reg_we    ( reg_we    ),
    .reg_addr  ( reg_addr  ),
    .cpu_dout  ( cpu_dout  ),
    .mmr_dout  ( mmr_dout  ),
    .busreq    ( busreq    ),
    .busack    ( busack    ),
    .vram_addr ( vram_addr ),
    .vram_data ( vram_data ),
    .vram_ok   ( vram_ok   ),
    .vram_cs   ( vram_cs   ),
    .pxl_in    ( pxl_in    ),
    .hdump     ( hdump     ),
    .vdump     ( vdump     ),
    .hb        ( hb        ),
    .vb        ( vb        ),
    .hs        ( hs        ),
    .vs        ( vs        ),
    .red       ( red       ),
    .green     ( green     ),
    .blue      ( blue      ),
    .lhbl_dly  ( lhbl_dly  ),
    .lvbl_dly  ( lvbl_dly  )
);

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
end

function automatic void report_failure();
    if (!fail_shown) begin
        fail_shown = 1'b1;
        $display("SOME TESTS FAILED");
    end
endfunction

task automatic stop_on_error();
    report_failure();
    $fatal(1, "run stopped at first error");
endtask

task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        stop_on_error();
    end
endtask

task automatic fail_plain(input string why);
    $display("%s", why);
    stop_on_error();
endtask

// Colour nibble widened to 8 bits, scaled by (brightness + 16) / 32
function automatic int expect_chan(input int nib, input int bright);
    return (nib * 17 * (bright + 16)) / 32;
endfunction

task automatic reg_write(input bus_pkg::reg_addr_t a, input bus_pkg::word_t d);
    @(negedge clk);
    reg_cs   <= 1'b1;
    reg_we   <= 1'b1;
    reg_addr <= a;
    cpu_dout <= d;
    @(negedge clk);
    reg_cs <= 1'b0;
    reg_we <= 1'b0;
    if (a == ADDR_BASE) begin
        sh_base = d;
    end
    if (a == ADDR_PAGES) begin
        sh_mask = d[`CPS_PAL_PAGES-1:0];
    end
endtask

task automatic reg_read(input bus_pkg::reg_addr_t a, output bus_pkg::word_t d);
    @(negedge clk);
    reg_cs   <= 1'b1;
    reg_we   <= 1'b0;
    reg_addr <= a;
    @(negedge clk);
    d = mmr_dout;
    reg_cs <= 1'b0;
endtask

// Enabled pages take base*128 + page*512 + entry, wrapped to the VRAM size
task automatic apply_copy(input int base, input video_pkg::page_mask_t mask);
    int src;
    for (int p = 0; p < `CPS_PAL_PAGES; p++) begin
        if (mask[p]) begin
            for (int e = 0; e < `CPS_PAGE_SIZE; e++) begin
                src = (base * 128 + p * `CPS_PAGE_SIZE + e) % VRAM_WORDS;
                model_pal[p * `CPS_PAGE_SIZE + e] = vmem[src];
            end
        end
    end
endtask

task automatic check_pixel(input int idx, input bit hbv, input bit vbv, input bit chk);
    video_pkg::pal_word_t w;
    compare("lhbl_dly", lhbl_dly, !hbv);
    compare("lvbl_dly", lvbl_dly, !vbv);
    if (hbv || vbv) begin
        compare("red", red, 0);
        compare("green", green, 0);
        compare("blue", blue, 0);
    end else if (chk) begin
        w = model_pal[idx];
        compare("red", red, expect_chan(w[11:8], w[15:12]));
        compare("green", green, expect_chan(w[7:4], w[15:12]));
        compare("blue", blue, expect_chan(w[3:0], w[15:12]));
        colour_checks++;
    end
endtask

task automatic wait_copies(input int n);
    while (copies_done < n) begin
        @(negedge clk);
    end
endtask

task automatic wait_line(input int line);
    do begin
        @(negedge clk);
    end while (!(vdump == video_pkg::vcount_t'(line) && hdump == '0));
endtask

// Grant follows the request after 0 to 20 cycles
initial begin : grant_model
    int delay;
    busack = 1'b0;
    delay = -1;
    forever begin
        @(negedge clk);
        if (rst || !busreq) begin
            busack <= 1'b0;
            delay = -1;
        end else if (!busack) begin
            if (delay < 0) begin
                delay = $urandom_range(20, 0);
            end
            if (delay == 0) begin
                busack <= 1'b1;
            end else begin
                delay--;
            end
        end
    end
end

// Each select answered after 1 to 5 cycles
initial begin : vram_model
    int wait_cnt;
    bit busy;
    vram_ok = 1'b0;
    vram_data = '0;
    busy = 1'b0;
    wait_cnt = 0;
    forever begin
        @(negedge clk);
        if (rst || vram_ok) begin
            vram_ok <= 1'b0;
            busy = 1'b0;
        end else if (vram_cs) begin
            if (!busy) begin
                busy = 1'b1;
                wait_cnt = $urandom_range(4, 0);
            end
            if (wait_cnt == 0) begin
                vram_ok   <= 1'b1;
                vram_data <= vmem[vram_addr];
            end else begin
                wait_cnt--;
            end
        end else begin
            busy = 1'b0;
        end
    end
end

// Copy bounds follow busreq; the model takes the copy when it ends
initial begin : copy_tracker
    bit busreq_q;
    busreq_q = 1'b0;
    forever begin
        @(negedge clk);
        if (busreq && !busreq_q) begin
            copies_started++;
            act_base = sh_base;
            act_mask = sh_mask;
        end
        if (!busreq && busreq_q) begin
            apply_copy(int'(act_base), act_mask);
            copies_done++;
        end
        busreq_q = busreq;
    end
end

// Raster counts, sync and frame start against a counter model; random
// pixels checked two clocks after they are driven
initial begin : raster_monitor
    int mh;
    int mv;
    int idx_q [2];
    bit hb_q [2];
    bit vb_q [2];
    bit chk_q [2];
    bit val_q [2];
    pxl_in = '0;
    mh = 0;
    mv = 0;
    val_q[0] = 1'b0;
    val_q[1] = 1'b0;
    forever begin
        @(negedge clk);
        if (rst) begin
            mh = 0;
            mv = 0;
            val_q[0] = 1'b0;
            val_q[1] = 1'b0;
        end else begin
            if (mh == `CPS_H_TOTAL - 1) begin
                mh = 0;
                mv = (mv == `CPS_V_TOTAL - 1) ? 0 : mv + 1;
            end else begin
                mh++;
            end
            compare("hdump", hdump, mh);
            compare("vdump", vdump, mv);
            compare("hb", hb, mh >= `CPS_H_ACTIVE);
            compare("vb", vb, mv >= `CPS_V_ACTIVE);
            compare("hs", hs, mh >= `CPS_HS_START && mh <= `CPS_HS_END);
            compare("vs", vs, mv >= `CPS_VS_START && mv <= `CPS_VS_END);
            compare("frame_start", dut.frame_start, mv == `CPS_V_ACTIVE && mh == 0);
            if (val_q[1]) begin
                check_pixel(idx_q[1], hb_q[1], vb_q[1], chk_q[1]);
            end
            idx_q[1] = idx_q[0];
            hb_q[1]  = hb_q[0];
            vb_q[1]  = vb_q[0];
            chk_q[1] = chk_q[0];
            val_q[1] = val_q[0];
            idx_q[0] = $urandom_range(PAL_USED - 1, 0);
            pxl_in <= video_pkg::pal_idx_t'(idx_q[0]);
            hb_q[0]  = mh >= `CPS_H_ACTIVE;
            vb_q[0]  = mv >= `CPS_V_ACTIVE;
            // No palette writes can reach a lookup made with busreq low
            chk_q[0] = pix_on && !busreq;
            val_q[0] = 1'b1;
        end
    end
end

initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout: the test sequence did not finish within 8 frames");
    stop_on_error();
end

final begin
    if (!passed) begin
        report_failure();
    end
end

initial begin : main_seq
    bus_pkg::word_t        rd;
    bus_pkg::word_t        val;
    bus_pkg::reg_addr_t    ua;
    video_pkg::page_mask_t m2;
    int                    p_off;
    int                    p_on;
    void'($urandom(32'hdb9e));
    rst = 1'b1;
    reg_cs = 1'b0;
    reg_we = 1'b0;
    reg_addr = '0;
    cpu_dout = '0;
    sh_base = '0;
    sh_mask = '0;
    copies_started = 0;
    copies_done = 0;
    colour_checks = 0;
    pix_on = 1'b0;
    passed = 1'b0;
    fail_shown = 1'b0;
    for (int a = 0; a < VRAM_WORDS; a++) begin
        vmem[a] = bus_pkg::word_t'($urandom);
    end
    repeat (4) @(negedge clk);
    rst <= 1'b0;

    // Register reset values, readback and unmapped words
    reg_read(ADDR_BASE, rd);
    compare("mmr_dout base", rd, 0);
    reg_read(ADDR_PAGES, rd);
    compare("mmr_dout pages", rd, 0);
    for (int i = 0; i < 8; i++) begin
        val = bus_pkg::word_t'($urandom);
        reg_write(ADDR_BASE, val);
        reg_read(ADDR_BASE, rd);
        compare("mmr_dout base", rd, val);
        val = bus_pkg::word_t'($urandom);
        reg_write(ADDR_PAGES, val);
        reg_read(ADDR_PAGES, rd);
        compare("mmr_dout pages", rd, val & 16'h003f);
        do begin
            ua = bus_pkg::reg_addr_t'($urandom);
        end while (ua == ADDR_BASE || ua == ADDR_PAGES);
        reg_read(ua, rd);
        compare("mmr_dout unmapped", rd, 0);
    end

    // Full copy, merged with the requests made above
    reg_write(ADDR_PAGES, 16'h003f);
    reg_write(ADDR_BASE, bus_pkg::word_t'($urandom));
    wait_copies(1);
    compare("copies started", copies_started, 1);
    pix_on = 1'b1;

    // Partial copy with at least one page on and one off
    p_off = $urandom_range(`CPS_PAL_PAGES - 1, 0);
    p_on  = (p_off + 1 + $urandom_range(`CPS_PAL_PAGES - 2, 0)) % `CPS_PAL_PAGES;
    m2 = video_pkg::page_mask_t'($urandom);
    m2[p_off] = 1'b0;
    m2[p_on]  = 1'b1;
    reg_write(ADDR_PAGES, bus_pkg::word_t'(m2));
    reg_write(ADDR_BASE, bus_pkg::word_t'($urandom));
    wait_line(0);
    wait_line(`CPS_V_ACTIVE);
    wait_copies(2);

    // Base written again while the next copy runs
    reg_write(ADDR_BASE, bus_pkg::word_t'($urandom));
    wait_line(0);
    wait_line(`CPS_V_ACTIVE);
    while (!busreq) begin
        @(negedge clk);
    end
    repeat ($urandom_range(200, 20)) @(negedge clk);
    if (!busreq) begin
        fail_plain("Copy finished before the base could be written during it");
    end
    reg_write(ADDR_BASE, bus_pkg::word_t'($urandom));
    wait_copies(3);
    compare("copies started", copies_started, 3);
    wait_copies(4);

    // One more visible area, then no copy may start at the next frame start
    wait_line(0);
    wait_line(`CPS_V_ACTIVE);
    repeat (8 * `CPS_H_TOTAL) @(negedge clk);
    compare("copies started", copies_started, 4);
    if (colour_checks == 0) begin
        fail_plain("No visible pixel was compared against the palette model");
    end

    passed = 1'b1;
    $display("ALL TESTS PASSED");
    $finish;
end

endmodule

`default_nettype wire

// ==== bench/cps_video_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module cps_video_assert (
    input wire                      clk,
    input wire                      rst,
    input wire                      busreq,
    input wire                      busack,
    input wire                      vram_cs,
    input wire                      vram_ok,
    input wire bus_pkg::vram_addr_t vram_addr,
    input wire                      frame_start,
    input wire video_pkg::chan_t    red,
    input wire video_pkg::chan_t    green,
    input wire video_pkg::chan_t    blue,
    input wire                      lhbl_dly,
    input wire                      lvbl_dly
);

// Video RAM is only selected while the bus is requested and granted
assert property (@(posedge clk) disable iff (rst) vram_cs |-> busack && busreq)
    else $error("vram_cs high without busreq and busack");

// Address held until the read is answered
assert property (@(posedge clk) disable iff (rst) vram_cs && !vram_ok |=> $stable(vram_addr))
    else $error("vram_addr changed before vram_ok");

assert property (@(posedge clk) disable iff (rst) frame_start |=> !frame_start)
    else $error("frame_start longer than one cycle");

// Black outside the visible area
assert property (@(posedge clk) disable iff (rst)
    !lhbl_dly || !lvbl_dly |-> red == '0 && green == '0 && blue == '0)
    else $error("colour output not black during blanking");

endmodule

bind cps_video cps_video_assert u_assert (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .busreq      ( busreq      ),
    .busack      ( busack      ),
    .vram_cs     ( vram_cs     ),
    .vram_ok     ( vram_ok     ),
    .vram_addr   ( vram_addr   ),
    .frame_start ( frame_start ),
    .red         ( red         ),
    .green       ( green       ),
    .blue        ( blue        ),
    .lhbl_dly    ( lhbl_dly    ),
    .lvbl_dly    ( lvbl_dly    )
);

`default_nettype wire

// ==== hw/cps_video.sv ====
`timescale 1ns/10ps
`default_nettype none

module cps_video (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       reg_cs,
    input  wire                       reg_we,
    input  wire bus_pkg::reg_addr_t   reg_addr,
    input  wire bus_pkg::word_t       cpu_dout,
    output bus_pkg::word_t            mmr_dout,
    output logic                      busreq,
    input  wire                       busack,
    output bus_pkg::vram_addr_t       vram_addr,
    input  wire bus_pkg::word_t       vram_data,
    input  wire                       vram_ok,
    output logic                      vram_cs,
    input  wire video_pkg::pal_idx_t  pxl_in,
    output video_pkg::hcount_t        hdump,
    output video_pkg::vcount_t        vdump,
    output logic                      hb,
    output logic                      vb,
    output logic                      hs,
    output logic                      vs,
    output video_pkg::chan_t          red,
    output video_pkg::chan_t          green,
    output video_pkg::chan_t          blue,
    output logic                      lhbl_dly,
    output logic                      lvbl_dly
);

logic                  frame_start;
bus_pkg::word_t        pal_base;
video_pkg::page_mask_t pal_page_en;
logic                  pal_copy;
logic                  pal_we;
video_pkg::pal_idx_t   pal_waddr;
video_pkg::pal_word_t  pal_wdata;

video_timing u_timing (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .hdump       ( hdump       ),
    .vdump       ( vdump       ),
    .hb          ( hb          ),
    .vb          ( vb          ),
    .hs          ( hs          ),
    .vs          ( vs          ),
    .frame_start ( frame_start )
);

ppu_regs u_regs (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .reg_cs      ( reg_cs      ),
    .reg_we      ( reg_we      ),
    .reg_addr    ( reg_addr    ),
    .cpu_dout    ( cpu_dout    ),
    .mmr_dout    ( mmr_dout    ),
    .pal_base    ( pal_base    ),
    .pal_page_en ( pal_page_en ),
    .pal_copy    ( pal_copy    )
);

pal_dma u_dma (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .frame_start ( frame_start ),
    .pal_copy    ( pal_copy    ),
    .busack      ( busack      ),
    .vram_ok     ( vram_ok     ),
    .pal_base    ( pal_base    ),
    .pal_page_en ( pal_page_en ),
    .vram_data   ( vram_data   ),
    .busreq      ( busreq      ),
    .vram_cs     ( vram_cs     ),
    .vram_addr   ( vram_addr   ),
    .pal_we      ( pal_we      ),
    .pal_waddr   ( pal_waddr   ),
    .pal_wdata   ( pal_wdata   )
);

pal_ram u_pal (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .pal_we      ( pal_we      ),
    .pal_waddr   ( pal_waddr   ),
    .pal_wdata   ( pal_wdata   ),
    .pxl_in      ( pxl_in      ),
    .hb          ( hb          ),
    .vb          ( vb          ),
    .red         ( red         ),
    .green       ( green       ),
    .blue        ( blue        ),
    .lhbl_dly    ( lhbl_dly    ),
    .lvbl_dly    ( lvbl_dly    )
);

endmodule

`default_nettype wire

// ==== hw/pal_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module pal_ram (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       pal_we,
    input  wire video_pkg::pal_idx_t  pal_waddr,
    input  wire video_pkg::pal_word_t pal_wdata,
    input  wire video_pkg::pal_idx_t  pxl_in,
    input  wire                       hb,
    input  wire                       vb,
    output video_pkg::chan_t          red,
    output video_pkg::chan_t          green,
    output video_pkg::chan_t          blue,
    output logic                      lhbl_dly,
    output logic                      lvbl_dly
);

localparam int DEPTH = 1 << $bits(video_pkg::pal_idx_t);

video_pkg::pal_word_t mem [0:DEPTH-1];
video_pkg::pal_word_t rd_word;
logic                 lhbl_d1;
logic                 lvbl_d1;

// Nibble scaled to 8 bits, then by (brightness + 16) / 32
function automatic video_pkg::chan_t conv(input logic [3:0] col, input logic [3:0] bright);
    logic [12:0] prod;
    prod = {5'd0, col, col} * {8'd0, 1'b1, bright};
    return prod[12:5];
endfunction

// Separate write and lookup ports
always_ff @(posedge clk) begin
    if (pal_we) begin
        mem[pal_waddr] <= pal_wdata;
    end
    rd_word <= mem[pxl_in];
end

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        lhbl_d1  <= 1'b0;
        lvbl_d1  <= 1'b0;
        lhbl_dly <= 1'b0;
        lvbl_dly <= 1'b0;
        red      <= '0;
        green    <= '0;
        blue     <= '0;
    end else begin
        lhbl_d1  <= ~hb;
        lvbl_d1  <= ~vb;
        lhbl_dly <= lhbl_d1;
        lvbl_dly <= lvbl_d1;
        if (lhbl_d1 && lvbl_d1) begin
            red   <= conv(rd_word[11:8], rd_word[15:12]);
            green <= conv(rd_word[7:4], rd_word[15:12]);
            blue  <= conv(rd_word[3:0], rd_word[15:12]);
        end else begin
            // Black during blanking
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end
    end
end

endmodule

`default_nettype wire

// ==== hw/pal_dma.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cps_video_settings.svh"

module pal_dma (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        frame_start,
    input  wire                        pal_copy,
    input  wire                        busack,
    input  wire                        vram_ok,
    input  wire bus_pkg::word_t        pal_base,
    input  wire video_pkg::page_mask_t pal_page_en,
    input  wire bus_pkg::word_t        vram_data,
    output logic                       busreq,
    output logic                       vram_cs,
    output bus_pkg::vram_addr_t        vram_addr,
    output logic                       pal_we,
    output video_pkg::pal_idx_t        pal_waddr,
    output video_pkg::pal_word_t       pal_wdata
);

localparam int PAGE_W  = $clog2(`CPS_PAL_PAGES);
localparam int ENTRY_W = $clog2(`CPS_PAGE_SIZE);

typedef enum logic [2:0] {
    ST_IDLE,
    ST_WAIT_FRAME,
    ST_REQ,
    ST_READ,
    ST_FINISH
} state_e;

state_e                state;
logic                  pending;
logic [PAGE_W-1:0]     page;
logic [ENTRY_W-1:0]    entry;
bus_pkg::word_t        base_l;
video_pkg::page_mask_t mask_l;
logic                  page_on;
logic                  last_entry;
logic                  last_page;
logic                  accept;

assign page_on    = mask_l[page];
assign last_entry = entry == ENTRY_W'(`CPS_PAGE_SIZE - 1);
assign last_page  = page == PAGE_W'(`CPS_PAL_PAGES - 1);
assign accept     = vram_cs && vram_ok;

assign busreq  = state == ST_REQ || state == ST_READ || state == ST_FINISH;
// Only enabled pages are read, and only with the bus granted
assign vram_cs = state == ST_READ && busack && page_on;

// Source walks base*128 + page*512 + entry, disabled pages included
assign vram_addr = (bus_pkg::vram_addr_t'(base_l) << `CPS_PAL_BASE_SHIFT)
                 + bus_pkg::vram_addr_t'({page, entry});

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        state   <= ST_IDLE;
        pending <= 1'b0;
        page    <= '0;
        entry   <= '0;
        pal_we  <= 1'b0;
    end else begin
        pal_we <= accept;
        if (pal_copy) begin
            pending <= 1'b1;
        end
        case (state)
            ST_IDLE: begin
                if (pending) begin
                    state <= ST_WAIT_FRAME;
                end
            end
            ST_WAIT_FRAME: begin
                if (frame_start) begin
                    state   <= ST_REQ;
                    pending <= pal_copy;
                    page    <= '0;
                    entry   <= '0;
                end
            end
            ST_REQ: begin
                if (busack) begin
                    state <= ST_READ;
                end
            end
            ST_READ: begin
                // Hold position while the grant is away
                if (busack) begin
                    if (!page_on || (accept && last_entry)) begin
                        entry <= '0;
                        page  <= page + 1'b1;
                        if (last_page) begin
                            state <= ST_FINISH;
                        end
                    end else if (accept) begin
                        entry <= entry + 1'b1;
                    end
                end
            end
            // Last palette write lands here, bus released next
            ST_FINISH: state <= ST_IDLE;
            default:   state <= ST_IDLE;
        endcase
    end
end

// Copy parameters and write payload
always_ff @(posedge clk) begin
    if (state == ST_WAIT_FRAME && frame_start) begin
        base_l <= pal_base;
        mask_l <= pal_page_en;
    end
    if (accept) begin
        pal_waddr <= video_pkg::pal_idx_t'({page, entry});
        pal_wdata <= vram_data;
    end
end

endmodule

`default_nettype wire

// ==== hw/ppu_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module ppu_regs (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        reg_cs,
    input  wire                        reg_we,
    input  wire bus_pkg::reg_addr_t    reg_addr,
    input  wire bus_pkg::word_t        cpu_dout,
    output bus_pkg::word_t             mmr_dout,
    output bus_pkg::word_t             pal_base,
    output video_pkg::page_mask_t      pal_page_en,
    output logic                       pal_copy
);

logic wr;

assign wr = reg_cs && reg_we;

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        pal_base    <= '0;
        pal_page_en <= '0;
        pal_copy    <= 1'b0;
    end else begin
        pal_copy <= 1'b0;
        if (wr) begin
            case (reg_addr)
                bus_pkg::REG_PAL_BASE: begin
                    pal_base <= cpu_dout;
                    // New base schedules a palette copy
                    pal_copy <= 1'b1;
                end
                bus_pkg::REG_PAL_PAGES: begin
                    pal_page_en <= cpu_dout[$bits(video_pkg::page_mask_t)-1:0];
                end
                default: begin
                end
            endcase
        end
    end
end

// Readback, unmapped words return zero
always_comb begin
    mmr_dout = '0;
    if (reg_cs) begin
        case (reg_addr)
            bus_pkg::REG_PAL_BASE:  mmr_dout = pal_base;
            bus_pkg::REG_PAL_PAGES: mmr_dout = bus_pkg::word_t'(pal_page_en);
            default:                mmr_dout = '0;
        endcase
    end
end

endmodule

`default_nettype wire

// ==== hw/video_timing.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cps_video_settings.svh"

module video_timing (
    input  wire                clk,
    input  wire                rst,
    output video_pkg::hcount_t hdump,
    output video_pkg::vcount_t vdump,
    output logic               hb,
    output logic               vb,
    output logic               hs,
    output logic               vs,
    output logic               frame_start
);

logic line_end;

assign line_end = hdump == video_pkg::hcount_t'(`CPS_H_TOTAL - 1);

// Nested line and frame counters
always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        hdump <= '0;
        vdump <= '0;
    end else begin
        hdump <= line_end ? '0 : hdump + 9'd1;
        if (line_end) begin
            if (vdump == video_pkg::vcount_t'(`CPS_V_TOTAL - 1)) begin
                vdump <= '0;
            end else begin
                vdump <= vdump + 9'd1;
            end
        end
    end
end

// Blanking and sync decoded straight from the counts
assign hb = hdump >= video_pkg::hcount_t'(`CPS_H_ACTIVE);
assign vb = vdump >= video_pkg::vcount_t'(`CPS_V_ACTIVE);
assign hs = hdump >= video_pkg::hcount_t'(`CPS_HS_START)
         && hdump <= video_pkg::hcount_t'(`CPS_HS_END);
assign vs = vdump >= video_pkg::vcount_t'(`CPS_VS_START)
         && vdump <= video_pkg::vcount_t'(`CPS_VS_END);

// First pixel of vertical blanking
assign frame_start = vdump == video_pkg::vcount_t'(`CPS_V_ACTIVE) && hdump == '0;

endmodule

`default_nettype wire

// ==== hw/bus_pkg.sv ====
`default_nettype none

`include "cps_video_settings.svh"

package bus_pkg;

    // CPU and video RAM data word
    typedef logic [15:0] word_t;

    // Register word index
    typedef logic [4:0] reg_addr_t;

    // Video RAM word address
    typedef logic [16:0] vram_addr_t;

    // Mapped register indices
    typedef enum logic [4:0] {
        REG_PAL_BASE  = 5'(`CPS_REG_PAL_BASE),
        REG_PAL_PAGES = 5'(`CPS_REG_PAL_PAGES)
    } reg_sel_e;

endpackage

`default_nettype wire

// ==== hw/video_pkg.sv ====
`default_nettype none

`include "cps_video_settings.svh"

package video_pkg;

    // Raster counts
    typedef logic [8:0] hcount_t;
    typedef logic [8:0] vcount_t;

    // Palette index as produced per pixel
    typedef logic [11:0] pal_idx_t;

    // Brightness in [15:12], then red, green and blue nibbles
    typedef logic [15:0] pal_word_t;

    // One output colour channel
    typedef logic [7:0] chan_t;

    // One enable bit per palette page
    typedef logic [`CPS_PAL_PAGES-1:0] page_mask_t;

endpackage

`default_nettype wire

// ==== hw/cps_video_settings.svh ====
`ifndef CPS_VIDEO_SETTINGS_SVH
`define CPS_VIDEO_SETTINGS_SVH

// Raster geometry, one pixel per clock
`define CPS_H_TOTAL        512
`define CPS_H_ACTIVE       384
`define CPS_HS_START       420
`define CPS_HS_END         451
`define CPS_V_TOTAL        262
`define CPS_V_ACTIVE       224
`define CPS_VS_START       240
`define CPS_VS_END         242

// Palette layout in video RAM and on chip
`define CPS_PAL_PAGES      6
`define CPS_PAGE_SIZE      512
`define CPS_PAL_BASE_SHIFT 7
`define CPS_OUT_DLY        2

// CPU register word indices
`define CPS_REG_PAL_BASE   5
`define CPS_REG_PAL_PAGES  24

`endif
